/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module uart_tb -f vlog.f -o uart_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi
./obj_dir/uart_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if grep -q "Finished with errors" sim.log; then
  exit 1
fi
exit 0

/* uart_apb.sv */
//////////////////////////////
// UART top level
// APB slave, FIFOs, TX/RX engines, interrupt unit
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module uart_apb import uart_pkg::*; #(
  parameter int APB_ADDR_W = 12,
  parameter int TX_DEPTH   = FIFO_DEPTH_DEF,
  parameter int RX_DEPTH   = FIFO_DEPTH_DEF
) (
  input  logic                  CLK,
  input  logic                  RSTN,
  input  logic [APB_ADDR_W-1:0] PADDR,
  input  logic [31:0]           PWDATA,
  input  logic                  PWRITE,
  input  logic                  PSEL,
  input  logic                  PENABLE,
  output logic [31:0]           PRDATA,
  output logic                  PREADY,
  output logic                  PSLVERR,
  input  logic                  rx_i,
  output logic                  tx_o,
  output logic                  event_o
);

  logic [$clog2(TX_DEPTH):0] tx_cnt;
  logic [$clog2(RX_DEPTH):0] rx_cnt;
  logic [7:0]                txf_data;
  logic                      txf_valid;
  logic                      txf_clr;
  logic [7:0]                tx_data;
  logic                      tx_valid;
  logic                      tx_ready;
  rx_word_t                  rx_word;
  logic                      rx_valid;
  logic                      rx_ready;
  rx_word_t                  rxf_word;
  logic                      rxf_valid;
  logic                      rxf_ready;
  logic                      rxf_clr;
  logic [2:0]                ier;
  logic [1:0]                trigger;
  logic [3:0]                clr_int;
  iir_code_t                 iir;

  assign PREADY  = 1'b1;  // zero wait states
  assign PSLVERR = 1'b0;

  uart_cfg_if u_cfg ();

  uart_regs #(.RX_DEPTH(RX_DEPTH), .TX_DEPTH(TX_DEPTH)) u_regs (
    .CLK, .RSTN,
    .paddr_i(PADDR[2:0]), .pwdata_i(PWDATA[7:0]), .pwrite_i(PWRITE),
    .psel_i(PSEL), .penable_i(PENABLE), .prdata_o(PRDATA),
    .cfg(u_cfg.src),
    .txf_data_o(txf_data), .txf_valid_o(txf_valid), .txf_count_i(tx_cnt),
    .txf_clr_o(txf_clr), .tx_idle_i(tx_ready),
    .rxf_word_i(rxf_word), .rxf_valid_i(rxf_valid), .rxf_ready_o(rxf_ready),
    .rxf_clr_o(rxf_clr), .rxf_count_i(rx_cnt),
    .ier_o(ier), .trigger_o(trigger), .clr_int_o(clr_int), .iir_i(iir)
  );

  // TX FIFO, fullness checked in the register block
  uart_fifo #(.T(logic [7:0]), .DEPTH(TX_DEPTH)) u_tx_fifo (
    .CLK, .RSTN, .clr_i(txf_clr),
    .in_data_i(txf_data), .in_valid_i(txf_valid), .in_ready_o(),
    .out_data_o(tx_data), .out_valid_o(tx_valid), .out_ready_i(tx_ready),
    .elements_o(tx_cnt)
  );

  uart_fifo #(.T(rx_word_t), .DEPTH(RX_DEPTH)) u_rx_fifo (
    .CLK, .RSTN, .clr_i(rxf_clr),
    .in_data_i(rx_word), .in_valid_i(rx_valid), .in_ready_o(rx_ready),
    .out_data_o(rxf_word), .out_valid_o(rxf_valid), .out_ready_i(rxf_ready),
    .elements_o(rx_cnt)
  );

  uart_tx u_tx (
    .CLK, .RSTN, .cfg(u_cfg.snk),
    .data_i(tx_data), .valid_i(tx_valid), .ready_o(tx_ready), .tx_o
  );

  uart_rx u_rx (
    .CLK, .RSTN, .cfg(u_cfg.snk),
    .rx_i, .word_o(rx_word), .valid_o(rx_valid), .ready_i(rx_ready)
  );

  uart_irq #(.RX_DEPTH(RX_DEPTH), .TX_DEPTH(TX_DEPTH)) u_irq (
    .CLK, .RSTN, .ier_i(ier),
    .rx_elements_i(rx_cnt), .tx_elements_i(tx_cnt),
    .rx_err_i(rx_valid & rx_ready & rx_word.perr),  // errored word stored
    .trigger_i(trigger), .clr_i(clr_int),
    .event_o, .iir_o(iir)
  );

endmodule

`default_nettype wire

/* uart_assertions.sv */
//////////////////////////////
// UART assertions
// APB ties, FIFO fill bounds, idle line level
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module uart_assertions import uart_pkg::*; #(
  parameter int TX_DEPTH = FIFO_DEPTH_DEF,
  parameter int RX_DEPTH = FIFO_DEPTH_DEF
) (
  input logic                      CLK,
  input logic                      RSTN,
  input logic                      pready_i,
  input logic                      pslverr_i,
  input logic [$clog2(TX_DEPTH):0] tx_cnt_i,
  input logic [$clog2(RX_DEPTH):0] rx_cnt_i,
  input logic                      tx_idle_i,  // shifter in idle
  input logic                      tx_line_i
);

  int fail_cnt = 0;  // assertion failures so far

  // zero wait and never an error response
  apb_ties: assert property (@(posedge CLK) disable iff (!RSTN) pready_i && !pslverr_i)
    else begin
      fail_cnt++;
      $error("APB ready/error ties broken");
    end

  fifo_bounds: assert property (@(posedge CLK) disable iff (!RSTN)
    (int'(tx_cnt_i) <= TX_DEPTH) && (int'(rx_cnt_i) <= RX_DEPTH))
    else begin
      fail_cnt++;
      $error("FIFO element count above depth");
    end

  // line stays at mark while nothing is queued for the shifter
  idle_line: assert property (@(posedge CLK) disable iff (!RSTN)
    (tx_idle_i && tx_cnt_i == '0) |=> tx_line_i)
    else begin
      fail_cnt++;
      $error("tx line low with no frame in progress");
    end

endmodule

bind uart_apb uart_assertions #(.TX_DEPTH(TX_DEPTH), .RX_DEPTH(RX_DEPTH)) u_assertions (
  .CLK(CLK), .RSTN(RSTN), .pready_i(PREADY), .pslverr_i(PSLVERR),
  .tx_cnt_i(tx_cnt), .rx_cnt_i(rx_cnt), .tx_idle_i(tx_ready), .tx_line_i(tx_o)
);

`default_nettype wire

/* uart_cfg_if.sv */
//////////////////////////////
// line configuration
// divisor and frame format, register block to both engines
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

interface uart_cfg_if import uart_pkg::*; ();

  logic [DIV_W-1:0] div;        // clocks per bit
  logic             parity_en;  // even parity bit present
  logic [1:0]       word_len;   // 0 -> 5 bits .. 3 -> 8 bits
  logic             stop2;      // two stop bits

  modport src (output div, parity_en, word_len, stop2);
  modport snk (input  div, parity_en, word_len, stop2);

endinterface

`default_nettype wire

/* uart_fifo.sv */
//////////////////////////////
// synchronous FIFO
// circular buffer, any payload type, clear and fill count
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module uart_fifo import uart_pkg::*; #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = FIFO_DEPTH_DEF
) (
  input  logic                   CLK,
  input  logic                   RSTN,
  input  logic                   clr_i,        // drop everything
  input  T                       in_data_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output T                       out_data_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output logic [$clog2(DEPTH):0] elements_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T                       mem [DEPTH];
  logic [AW-1:0]          wr_ptr_q;
  logic [AW-1:0]          rd_ptr_q;
  logic [$clog2(DEPTH):0] count_q;
  logic                   push;
  logic                   pop;

  // wrap at DEPTH, not only at powers of two
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign in_ready_o  = (count_q < DEPTH);
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem[rd_ptr_q];  // head, valid the cycle after the write
  assign elements_o  = count_q;

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clr_i) begin  // single-cycle flush
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;  // both or neither, level unchanged
      endcase
    end
  end

  // storage
  always_ff @(posedge CLK) begin
    if (push) mem[wr_ptr_q] <= in_data_i;
  end

endmodule

`default_nettype wire

/* uart_irq.sv */
//////////////////////////////
// interrupt unit
// pending flags, priority RLS > RDA > THRE, IIR code
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module uart_irq import uart_pkg::*; #(
  parameter int RX_DEPTH = FIFO_DEPTH_DEF,
  parameter int TX_DEPTH = FIFO_DEPTH_DEF
) (
  input  logic                      CLK,
  input  logic                      RSTN,
  input  logic [2:0]                ier_i,          // {rls, thre, rda}
  input  logic [$clog2(RX_DEPTH):0] rx_elements_i,
  input  logic [$clog2(TX_DEPTH):0] tx_elements_i,
  input  logic                      rx_err_i,       // errored word stored
  input  logic [1:0]                trigger_i,
  input  logic [3:0]                clr_i,          // {rx clr, lsr, iir, rbr}
  output logic                      event_o,
  output iir_code_t                 iir_o
);

  localparam int RXW = $clog2(RX_DEPTH) + 1;

  logic [RXW-1:0] trig_lvl;
  logic           rda_q;
  logic           thre_q;
  logic           rls_q;
  logic           tx_busy_q;  // TX FIFO held data last cycle
  logic [2:0]     act;        // enabled and pending

  always_comb begin
    case (trigger_i)
      2'd0:    trig_lvl = RXW'(1);
      2'd1:    trig_lvl = RXW'(4);
      2'd2:    trig_lvl = RXW'(8);
      default: trig_lvl = RXW'(14);
    endcase
  end

  assign act = ier_i & {rls_q, thre_q, rda_q};

  always_comb begin
    if (act[2])      iir_o = RLS;
    else if (act[0]) iir_o = RDA;
    else if (act[1]) iir_o = THRE;
    else             iir_o = NONE;
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      rda_q     <= 1'b0;
      thre_q    <= 1'b0;
      rls_q     <= 1'b0;
      tx_busy_q <= 1'b0;
      event_o   <= 1'b0;
    end else begin
      rda_q     <= (rx_elements_i >= trig_lvl) && !clr_i[0];  // level, masked on pop
      tx_busy_q <= (tx_elements_i != '0);
      if (clr_i[1])                                thre_q <= 1'b0;
      else if (tx_busy_q && tx_elements_i == '0)   thre_q <= 1'b1;  // drained
      if (clr_i[2] || clr_i[3]) rls_q <= 1'b0;
      else if (rx_err_i)        rls_q <= 1'b1;
      event_o   <= |act;
    end
  end

endmodule

`default_nettype wire

/* uart_pkg.sv */
//////////////////////////////
// uart package
// register map, LCR/LSR fields, RX payload and IIR codes
//////////////////////////////
`default_nettype none

package uart_pkg;

  localparam int DIV_W          = 16;  // divisor latch width
  localparam int FIFO_DEPTH_DEF = 16;  // entries per FIFO

  // byte offsets, DLL/DLM share 0/1 under DLAB
  typedef enum logic [2:0] {
    RBR_THR = 3'd0,
    IER_DLM = 3'd1,
    IIR_FCR = 3'd2,
    LCR     = 3'd3,
    LSR     = 3'd5
  } reg_offset_t;

  // LCR fields, bits 1:0 are the word length minus 5
  localparam int LCR_DLAB = 7;
  localparam int LCR_PEN  = 3;
  localparam int LCR_STB  = 2;

  // LSR fields
  localparam int LSR_DR   = 0;
  localparam int LSR_PE   = 2;
  localparam int LSR_THRE = 5;
  localparam int LSR_TEMT = 6;

  // received character plus its parity flag
  typedef struct packed {
    logic       perr;
    logic [7:0] data;
  } rx_word_t;

  typedef enum logic [3:0] {
    NONE = 4'h1,  // nothing pending
    THRE = 4'h2,
    RDA  = 4'h4,
    RLS  = 4'h6   // highest priority
  } iir_code_t;

endpackage

`default_nettype wire

/* uart_regs.sv */
//////////////////////////////
// UART register block
// APB decode with DLAB, LCR/IER/DLL/DLM, LSR, FIFO control
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module uart_regs import uart_pkg::*; #(
  parameter int RX_DEPTH = FIFO_DEPTH_DEF,
  parameter int TX_DEPTH = FIFO_DEPTH_DEF
) (
  input  logic                      CLK,
  input  logic                      RSTN,
  // APB
  input  logic [2:0]                paddr_i,
  input  logic [7:0]                pwdata_i,
  input  logic                      pwrite_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  output logic [31:0]               prdata_o,
  // line config
  uart_cfg_if.src                   cfg,
  // TX side
  output logic [7:0]                txf_data_o,
  output logic                      txf_valid_o,
  input  logic [$clog2(TX_DEPTH):0] txf_count_i,
  output logic                      txf_clr_o,
  input  logic                      tx_idle_i,
  // RX side
  input  rx_word_t                  rxf_word_i,
  input  logic                      rxf_valid_i,
  output logic                      rxf_ready_o,
  output logic                      rxf_clr_o,
  input  logic [$clog2(RX_DEPTH):0] rxf_count_i,
  // interrupts
  output logic [2:0]                ier_o,
  output logic [1:0]                trigger_o,
  output logic [3:0]                clr_int_o,
  input  iir_code_t                 iir_i
);

  logic [7:0] lcr_q;
  logic [7:0] ier_q;
  logic [7:0] dll_q;
  logic [7:0] dlm_q;
  logic [7:0] lsr;
  logic [1:0] trig_q;
  logic       txf_clr_q;
  logic       rxf_clr_q;
  logic       wr_en;
  logic       rd_en;
  logic       dlab;
  logic       fcr_wr;

  assign wr_en  = psel_i & penable_i & pwrite_i;  // access phase, PREADY always 1
  assign rd_en  = psel_i & penable_i & ~pwrite_i;
  assign dlab   = lcr_q[LCR_DLAB];
  assign fcr_wr = wr_en && (paddr_i == IIR_FCR);

  assign cfg.div       = {dlm_q, dll_q};
  assign cfg.parity_en = lcr_q[LCR_PEN];
  assign cfg.word_len  = lcr_q[1:0];
  assign cfg.stop2     = lcr_q[LCR_STB];

  assign ier_o     = ier_q[2:0];
  assign trigger_o = trig_q;
  assign txf_clr_o = txf_clr_q;
  assign rxf_clr_o = rxf_clr_q;

  // THR push, full FIFO drops the byte
  assign txf_data_o  = pwdata_i;
  assign txf_valid_o = wr_en && (paddr_i == RBR_THR) && !dlab && (txf_count_i < TX_DEPTH);

  ////////////////////////////////
  // line status
  ////////////////////////////////
  always_comb begin
    lsr           = '0;
    lsr[LSR_DR]   = (rxf_count_i != '0);
    lsr[LSR_PE]   = rxf_valid_i & rxf_word_i.perr;   // flag of head word
    lsr[LSR_THRE] = (txf_count_i == '0);
    lsr[LSR_TEMT] = (txf_count_i == '0) & tx_idle_i;  // shifter idle too
  end

  ////////////////////////////////
  // read mux and side effects
  ////////////////////////////////
  always_comb begin
    prdata_o    = '0;
    rxf_ready_o = 1'b0;
    clr_int_o   = '0;
    if (rd_en) begin
      case (paddr_i)
        RBR_THR: begin
          if (dlab) begin
            prdata_o[7:0] = dll_q;
          end else begin
            prdata_o[7:0] = rxf_valid_i ? rxf_word_i.data : 8'h00;
            rxf_ready_o   = 1'b1;  // pop at end of access
            clr_int_o[0]  = 1'b1;
          end
        end
        IER_DLM: prdata_o[7:0] = dlab ? dlm_q : ier_q;
        IIR_FCR: begin
          prdata_o[7:0] = {4'hC, iir_i};  // FIFOs always on
          clr_int_o[1]  = 1'b1;
        end
        LCR:     prdata_o[7:0] = lcr_q;
        LSR: begin
          prdata_o[7:0] = lsr;
          clr_int_o[2]  = 1'b1;
        end
        default: ;
      endcase
    end
    if (fcr_wr && pwdata_i[1]) clr_int_o[3] = 1'b1;  // RX flush drops line error
  end

  ////////////////////////////////
  // register writes
  ////////////////////////////////
  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      lcr_q     <= '0;
      ier_q     <= '0;
      dll_q     <= '0;
      dlm_q     <= '0;
      trig_q    <= '0;
      txf_clr_q <= 1'b0;
      rxf_clr_q <= 1'b0;
    end else begin
      rxf_clr_q <= fcr_wr & pwdata_i[1];  // self clearing
      txf_clr_q <= fcr_wr & pwdata_i[2];
      if (wr_en) begin
        case (paddr_i)
          RBR_THR: if (dlab) dll_q <= pwdata_i;
          IER_DLM: begin
            if (dlab) dlm_q <= pwdata_i;
            else      ier_q <= pwdata_i;
          end
          IIR_FCR: trig_q <= pwdata_i[7:6];
          LCR:     lcr_q  <= pwdata_i;
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* uart_rx.sv */
//////////////////////////////
// UART receiver
// start detect, mid-bit sampling, even parity check
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module uart_rx import uart_pkg::*; (
  input  logic     CLK,
  input  logic     RSTN,
  uart_cfg_if.snk  cfg,
  input  logic     rx_i,
  output rx_word_t word_o,
  output logic     valid_o,
  input  logic     ready_i
);

  typedef enum logic [2:0] {S_IDLE, S_START, S_DATA, S_PAR, S_STOP} state_t;

  state_t           state_q;
  logic [1:0]       sync_q;   // two-flop synchroniser
  logic             prev_q;   // last synchronised level
  logic             rx_s;
  logic [DIV_W-1:0] cnt_q;
  logic [DIV_W-1:0] cnt_end;
  logic [2:0]       bit_q;
  logic [7:0]       data_q;
  logic             par_q;
  logic             perr_q;
  logic             valid_q;
  logic             start;
  logic             tick;     // sample point

  assign rx_s  = sync_q[1];
  assign start = (state_q == S_IDLE) && prev_q && !rx_s;  // falling edge

  // half a bit to the start-bit centre, then full bits
  assign cnt_end = (state_q == S_START) ? (cfg.div >> 1) - 1'b1 : cfg.div - 1'b1;
  assign tick    = (cnt_q == cnt_end);

  assign word_o  = {perr_q, data_q};
  assign valid_o = valid_q;

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      sync_q  <= 2'b11;
      prev_q  <= 1'b1;
      state_q <= S_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
      par_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], rx_i};
      prev_q <= rx_s;

      if (state_q == S_IDLE || tick) cnt_q <= '0;
      else                           cnt_q <= cnt_q + 1'b1;

      // word not taken before the next frame is lost
      if (start || (valid_q && ready_i)) valid_q <= 1'b0;

      case (state_q)
        S_IDLE: if (start) state_q <= S_START;
        S_START: if (tick) begin
          state_q <= rx_s ? S_IDLE : S_DATA;  // glitch returns to idle
          bit_q   <= '0;
          par_q   <= 1'b0;
        end
        S_DATA: if (tick) begin
          par_q <= par_q ^ rx_s;
          bit_q <= bit_q + 1'b1;
          if (bit_q == {1'b0, cfg.word_len} + 3'd4)
            state_q <= cfg.parity_en ? S_PAR : S_STOP;
        end
        S_PAR: if (tick) state_q <= S_STOP;
        S_STOP: if (tick) begin  // mid stop bit, hand word over
          valid_q <= 1'b1;
          state_q <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // assembled word, zero above word length
  always_ff @(posedge CLK) begin
    if (start) begin
      data_q <= '0;
      perr_q <= 1'b0;
    end else if (tick && state_q == S_DATA) begin
      data_q[bit_q] <= rx_s;
    end else if (tick && state_q == S_PAR) begin
      perr_q <= par_q ^ rx_s;  // even parity, xor of all must be 0
    end
  end

endmodule

`default_nettype wire

/* uart_tb.sv */
//////////////////////////////
// UART testbench
// APB access, loopback traffic, queue model, timeout
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module uart_tb import uart_pkg::*; ;

  localparam int DIV      = 8;
  localparam int N_FRAMES = 26;  // 20 data, 1 parity, 2 irq, 3 clear
  localparam int TIMEOUT  = N_FRAMES * 12 * DIV * 2 + 4000;  // plus APB polling margin

  localparam logic [7:0] DR_M   = 8'(1 << LSR_DR);
  localparam logic [7:0] PE_M   = 8'(1 << LSR_PE);
  localparam logic [7:0] THRE_M = 8'(1 << LSR_THRE);
  localparam logic [7:0] TEMT_M = 8'(1 << LSR_TEMT);

  logic        CLK;
  logic        RSTN;
  logic [11:0] PADDR;
  logic [31:0] PWDATA;
  logic        PWRITE;
  logic        PSEL;
  logic        PENABLE;
  logic [31:0] PRDATA;
  logic        PREADY;
  logic        PSLVERR;
  logic        rx_i;
  logic        tx_o;
  logic        event_o;
  logic        loop_en;   // 1 -> tx_o feeds rx_i
  logic        rx_drv;    // line level driven by the testbench
  logic [7:0]  exp_q [$];  // bytes expected from RBR
  int          err_cnt = 0;
  int          chk_cnt = 0;
  int          cycles  = 0;

  assign rx_i = loop_en ? tx_o : rx_drv;

  uart_tb_clk u_clk (.CLK(CLK), .RSTN(RSTN));

  uart_apb #(.APB_ADDR_W(12)) u_uart_apb (
    .CLK(CLK), .RSTN(RSTN),
    .PADDR(PADDR), .PWDATA(PWDATA), .PWRITE(PWRITE), .PSEL(PSEL), .PENABLE(PENABLE),
    .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
    .rx_i(rx_i), .tx_o(tx_o), .event_o(event_o)
  );

  ////////////////////////////////
  // bus and line tasks
  ////////////////////////////////
  // all start 1 ns after a rising edge
  task automatic write_reg(input logic [2:0] off, input logic [7:0] data);
    PADDR   = {9'd0, off};
    PWDATA  = {24'd0, data};
    PWRITE  = 1'b1;
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    @(posedge CLK);
    #1 PENABLE = 1'b1;  // access phase
    @(posedge CLK);     // write lands here
    #1 PSEL = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
  endtask

  task automatic read_reg(input logic [2:0] off, output logic [7:0] data);
    PADDR   = {9'd0, off};
    PWRITE  = 1'b0;
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    @(posedge CLK);
    #1 PENABLE = 1'b1;
    @(negedge CLK);
    data = PRDATA[7:0];  // combinational in the access phase
    @(posedge CLK);
    #1 PSEL = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR %0t %s: got 0x%02h expected 0x%02h", $time, name, got, exp);
    end
  endtask

  task automatic expect_reg(input logic [2:0] off, input string name, input logic [7:0] exp);
    logic [7:0] v;
    read_reg(off, v);
    check_val(name, v, exp);
  endtask

  // spin on LSR until a masked bit shows
  task automatic poll_lsr(input logic [7:0] mask);
    logic [7:0] v;
    v = 8'h00;
    while ((v & mask) == 8'h00) read_reg(LSR, v);
  endtask

  task automatic send_byte(input logic [7:0] b, input logic [1:0] wl);
    exp_q.push_back(b & 8'((1 << (wl + 5)) - 1));  // receiver zero fills
    write_reg(RBR_THR, b);
  endtask

  // pops every queued byte with DR up and PE clear before each read
  task automatic drain_rx();
    logic [7:0] v;
    logic [7:0] want;
    while (exp_q.size() > 0) begin
      read_reg(LSR, v);
      check_val("LSR.DR/PE", v & (DR_M | PE_M), DR_M);
      want = exp_q.pop_front();
      expect_reg(RBR_THR, "RBR", want);
    end
    expect_reg(LSR, "LSR", THRE_M | TEMT_M);
  endtask

  task automatic hold_bit();
    repeat (DIV) @(posedge CLK);
    #1;
  endtask

  // 8 data bits, even parity (optionally inverted), 1 stop
  task automatic drive_frame(input logic [7:0] data, input logic bad_par);
    rx_drv = 1'b0;
    hold_bit();
    for (int i = 0; i < 8; i++) begin
      rx_drv = data[i];
      hold_bit();
    end
    rx_drv = ^data ^ bad_par;
    hold_bit();
    rx_drv = 1'b1;
    hold_bit();
  endtask

  task automatic wait_event_high();
    while (event_o !== 1'b1) begin
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic check_event_low();
    repeat (2) @(posedge CLK);  // flag clears and event_o follows a cycle later
    #1 check_val("event_o", {7'd0, event_o}, 8'h00);
  endtask

  ////////////////////////////////
  // watchdog
  ////////////////////////////////
  always @(posedge CLK) begin
    cycles++;
    if (cycles > TIMEOUT) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  ////////////////////////////////
  // test sequence
  ////////////////////////////////
  initial begin
    logic [7:0] b;
    logic [7:0] v;
    logic [7:0] lcr_v;
    int         total;
    PADDR   = '0;
    PWDATA  = '0;
    PWRITE  = 1'b0;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    rx_drv  = 1'b1;
    loop_en = 1'b1;
    void'($urandom(17825));
    @(posedge RSTN);
    @(posedge CLK);
    #1;

    // reset values
    expect_reg(LSR, "LSR", THRE_M | TEMT_M);
    expect_reg(IIR_FCR, "IIR", 8'hC1);
    expect_reg(LCR, "LCR", 8'h00);
    expect_reg(IER_DLM, "IER", 8'h00);
    check_val("event_o", {7'd0, event_o}, 8'h00);

    // readback with DLAB muxing on offsets 0/1
    write_reg(IER_DLM, 8'h0A);
    expect_reg(IER_DLM, "IER", 8'h0A);
    write_reg(LCR, 8'h9B);
    expect_reg(LCR, "LCR", 8'h9B);
    write_reg(RBR_THR, 8'(DIV));
    write_reg(IER_DLM, 8'hA5);
    expect_reg(RBR_THR, "DLL", 8'(DIV));
    expect_reg(IER_DLM, "DLM", 8'hA5);
    write_reg(IER_DLM, 8'h00);  // divisor = DIV
    write_reg(LCR, 8'h03);
    expect_reg(IER_DLM, "IER", 8'h0A);
    write_reg(IER_DLM, 8'h00);

    // loopback in 5 groups of 4 with a random frame format per group
    for (int g = 0; g < 5; g++) begin
      lcr_v = 8'($urandom) & 8'h0F;  // word length, stop bits, parity
      write_reg(LCR, lcr_v);
      for (int k = 0; k < 4; k++) begin
        b = 8'($urandom);
        send_byte(b, lcr_v[1:0]);
      end
      poll_lsr(TEMT_M);  // last word is in the RX FIFO by now
      drain_rx();
    end

    // parity error frame from the testbench
    write_reg(LCR, 8'h0B);
    loop_en = 1'b0;
    b = 8'($urandom);
    drive_frame(b, 1'b1);
    poll_lsr(DR_M);
    read_reg(LSR, v);
    check_val("LSR.PE", v & PE_M, PE_M);
    expect_reg(RBR_THR, "RBR", b);
    expect_reg(LSR, "LSR", THRE_M | TEMT_M);
    loop_en = 1'b1;

    // RDA interrupt at trigger level 1
    write_reg(LCR, 8'h03);
    write_reg(IIR_FCR, 8'h00);
    write_reg(IER_DLM, 8'h01);
    send_byte(8'($urandom), 2'd3);
    wait_event_high();
    expect_reg(IIR_FCR, "IIR", 8'hC4);
    expect_reg(RBR_THR, "RBR", exp_q.pop_front());
    check_event_low();

    // THRE interrupt cleared by the IIR read
    write_reg(IER_DLM, 8'h02);
    send_byte(8'($urandom), 2'd3);
    wait_event_high();
    expect_reg(IIR_FCR, "IIR", 8'hC2);
    check_event_low();
    poll_lsr(TEMT_M);
    drain_rx();
    write_reg(IER_DLM, 8'h00);

    // RX FIFO clear
    for (int k = 0; k < 3; k++) send_byte(8'($urandom), 2'd3);
    poll_lsr(TEMT_M);
    expect_reg(LSR, "LSR", THRE_M | TEMT_M | DR_M);
    write_reg(IIR_FCR, 8'h02);
    expect_reg(LSR, "LSR", THRE_M | TEMT_M);
    expect_reg(RBR_THR, "RBR", 8'h00);  // empty FIFO pops nothing
    expect_reg(LSR, "LSR", THRE_M | TEMT_M);
    exp_q.delete();

    total = err_cnt + u_uart_apb.u_assertions.fail_cnt;
    $display("checks %0d, errors %0d, assertion failures %0d",
             chk_cnt, err_cnt, u_uart_apb.u_assertions.fail_cnt);
    if (total == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* uart_tb_clk.sv */
//////////////////////////////
// testbench clock and reset
// 10 ns clock, reset low for 10 cycles
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module uart_tb_clk (
  output logic CLK,
  output logic RSTN
);

  initial CLK = 1'b0;
  always #5 CLK = ~CLK;  // 100 MHz

  initial begin
    RSTN = 1'b0;
    repeat (10) @(posedge CLK);
    #1 RSTN = 1'b1;  // release off the edge
  end

endmodule

`default_nettype wire

/* uart_tx.sv */
//////////////////////////////
// UART transmitter
// start, 5..8 data bits LSB first, even parity, 1/2 stop
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module uart_tx import uart_pkg::*; (
  input  logic       CLK,
  input  logic       RSTN,
  uart_cfg_if.snk    cfg,
  input  logic [7:0] data_i,
  input  logic       valid_i,
  output logic       ready_o,
  output logic       tx_o
);

  typedef enum logic [2:0] {S_IDLE, S_START, S_DATA, S_PAR, S_STOP} state_t;

  state_t           state_q;
  logic [DIV_W-1:0] baud_q;   // clocks into current bit
  logic [2:0]       bit_q;    // data bit index
  logic [7:0]       shift_q;  // LSB goes out first
  logic             par_q;    // running even parity
  logic             stop2_q;  // in second stop bit
  logic             tick;     // last clock of a bit

  assign tick    = (baud_q == cfg.div - 1'b1);
  assign ready_o = (state_q == S_IDLE);

  always_comb begin
    case (state_q)
      S_START: tx_o = 1'b0;
      S_DATA:  tx_o = shift_q[0];
      S_PAR:   tx_o = par_q;
      default: tx_o = 1'b1;  // idle and stop are mark
    endcase
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      state_q <= S_IDLE;
      baud_q  <= '0;
      bit_q   <= '0;
      par_q   <= 1'b0;
      stop2_q <= 1'b0;
    end else begin
      if (state_q == S_IDLE || tick) baud_q <= '0;
      else                           baud_q <= baud_q + 1'b1;

      case (state_q)
        S_IDLE: if (valid_i) begin  // accepted, start bit next edge
          state_q <= S_START;
          bit_q   <= '0;
          par_q   <= 1'b0;
          stop2_q <= 1'b0;
        end
        S_START: if (tick) state_q <= S_DATA;
        S_DATA: if (tick) begin
          par_q <= par_q ^ shift_q[0];
          bit_q <= bit_q + 1'b1;
          if (bit_q == {1'b0, cfg.word_len} + 3'd4)  // last of word_len+5
            state_q <= cfg.parity_en ? S_PAR : S_STOP;
        end
        S_PAR: if (tick) state_q <= S_STOP;
        S_STOP: if (tick) begin
          if (cfg.stop2 && !stop2_q) stop2_q <= 1'b1;
          else                       state_q <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // shift register, loaded on accept
  always_ff @(posedge CLK) begin
    if (ready_o && valid_i)             shift_q <= data_i;
    else if (state_q == S_DATA && tick) shift_q <= {1'b0, shift_q[7:1]};
  end

endmodule

`default_nettype wire

/* vlog.f */
uart_pkg.sv
uart_cfg_if.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_irq.sv
uart_regs.sv
uart_apb.sv
uart_tb_clk.sv
uart_assertions.sv
uart_tb.sv
